/* design/board_settings.svh */
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

//------------------------------------------------------------
// Board resources
//------------------------------------------------------------

`define BOARD_CLK_MHZ   50      // Onboard oscillator
`define BOARD_W_KEY     2       // Push buttons, active low on the board
`define BOARD_W_SW      4       // Slide switches, top one is reset
`define BOARD_W_LED     8       // Level bar LEDs

//------------------------------------------------------------
// Audio word widths
//------------------------------------------------------------

`define MIC_SAMPLE_W    24      // INMP441 data word
`define SOUND_W         16      // Word sent to the DAC

//------------------------------------------------------------
// I2S timing
//------------------------------------------------------------

// Half periods in system clocks, small values keep simulation short
`define MIC_SCK_DIV     4
`define AUD_BCLK_DIV    4

`define I2S_SLOT_BITS   32      // Bit clocks per channel slot

`endif

/* design/board_pkg.sv */
`include "board_settings.svh"

package board_pkg;

    //------------------------------------------------------------
    // Audio path
    //------------------------------------------------------------

    // Raw microphone word, two's complement
    typedef logic signed [`MIC_SAMPLE_W - 1:0] mic_sample_t;

    typedef logic signed [`SOUND_W - 1:0]      sound_t;         // DAC word

    //------------------------------------------------------------
    // Lab controls and indicators
    //------------------------------------------------------------

    typedef logic        [`BOARD_W_LED - 1:0]  led_bar_t;       // Thermometer bar

    // Right shift amount, all switches except the reset one
    typedef logic        [`BOARD_W_SW - 2:0]   atten_t;

endpackage

/* design/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/1ps

`include "board_settings.svh"

module inmp441_mic_i2s_receiver
#(
    parameter int clk_mhz = `BOARD_CLK_MHZ
)
(
    input  logic                   clk,
    input  logic                   rst,
    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    input  logic                   sd,
    output board_pkg::mic_sample_t sample,
    output logic                   sample_req,
    input  logic                   sample_ack
);

    import board_pkg::*;

    localparam int div_w    = $clog2(`MIC_SCK_DIV + 1);
    localparam int cnt_w    = $clog2(2 * `I2S_SLOT_BITS);     // Bit clocks per frame
    localparam int data_w   = $bits(mic_sample_t);
    localparam int frame_hz = clk_mhz * 1_000_000 / (4 * `MIC_SCK_DIV * `I2S_SLOT_BITS);

    logic [div_w - 1:0] div_cnt;
    logic               div_end;
    logic               sck_rise;
    logic               sck_fall;
    logic [cnt_w - 1:0] bit_cnt;        // Position in frame, MSB is ws
    logic               capture;
    mic_sample_t        shift_reg;
    logic               word_done;      // Last data bit just shifted in
    logic               ack_wait;       // Req dropped, waiting for ack low
    logic               overrun;        // Sticky, a word was lost

    // Mic stops outputting below its minimum frame rate
    if (frame_hz < 4_000)
    begin : g_rate_check
        $error("Microphone frame rate below sensor minimum");
    end

    //------------------------------------------------------------
    // Bit clock and word select
    //------------------------------------------------------------

    assign div_end  = (div_cnt == div_w'(`MIC_SCK_DIV - 1));
    assign sck_rise = div_end & ~sck;
    assign sck_fall = div_end &  sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '1;                              // ws high until first frame
        end
        else
        begin
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;
            if (div_end)
                sck <= ~sck;
            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;              // ws moves on falling sck
        end
    end

    assign ws = bit_cnt[cnt_w - 1];                     // Low during left slot
    assign lr = 1'b0;                                   // Sensor drives left slot

    //------------------------------------------------------------
    // Left slot capture, one bit clock after ws falls
    //------------------------------------------------------------

    assign capture = sck_rise & ~ws & (bit_cnt >= cnt_w'(1)) & (bit_cnt <= cnt_w'(data_w));

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_reg <= {shift_reg[data_w - 2:0], sd};  // MSB first
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            word_done <= 1'b0;
        else
            word_done <= sck_rise & ~ws & (bit_cnt == cnt_w'(data_w));
    end

    //------------------------------------------------------------
    // Four phase handshake toward the lab
    //------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample_req <= 1'b0;
            ack_wait   <= 1'b0;
            overrun    <= 1'b0;
        end
        else
        begin
            if (sample_req)
            begin
                if (sample_ack)
                begin
                    sample_req <= 1'b0;
                    ack_wait   <= 1'b1;
                end
            end
            else if (ack_wait)
            begin
                if (!sample_ack)
                    ack_wait <= 1'b0;                   // Ready for next word
            end
            else if (word_done)
                sample_req <= 1'b1;

            if (word_done && (sample_req || ack_wait))
                overrun <= 1'b1;                        // New word dropped
        end
    end

    always_ff @(posedge clk)
    begin
        if (word_done && !sample_req && !ack_wait)
            sample <= shift_reg;                        // Same edge as req rise
    end

    // Lab sees one value for the whole request
    assert property (@(posedge clk) disable iff (rst)
        sample_req |=> !sample_req || $stable(sample));

    // No withdrawal of a request the lab has not taken
    assert property (@(posedge clk) disable iff (rst)
        sample_req && !sample_ack |=> sample_req);

    assert property (@(posedge clk) disable iff (rst) !overrun);

endmodule

/* design/sound_level_lab.sv */
`timescale 1ns/1ps

`include "board_settings.svh"

module sound_level_lab
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`BOARD_W_KEY - 1:0] key,
    input  board_pkg::atten_t         sw,
    input  board_pkg::mic_sample_t    sample,
    input  logic                      sample_req,
    output logic                      sample_ack,
    output board_pkg::sound_t         sound,
    output board_pkg::led_bar_t       level
);

    import board_pkg::*;

    localparam int sound_w = $bits(sound_t);
    localparam int led_w   = $bits(led_bar_t);

    // LED 0 threshold exponent, top LED sits at the sign bit
    localparam int level_base = sound_w - led_w;

    localparam sound_t sound_min = {1'b1, {(sound_w - 1){1'b0}}};
    localparam sound_t sound_max = {1'b0, {(sound_w - 1){1'b1}}};

    sound_t               upper;        // Top bits of the mic word
    sound_t               scaled;
    sound_t               next_sound;
    logic [sound_w - 1:0] magnitude;
    led_bar_t             next_level;
    logic                 accept;

    //------------------------------------------------------------
    // Attenuation and mute
    //------------------------------------------------------------

    assign upper      = sample[$bits(mic_sample_t) - 1 -: sound_w];
    assign scaled     = upper >>> sw;                   // Sign kept while dividing
    assign next_sound = key[0] ? '0 : scaled;           // Key 0 pressed mutes

    //------------------------------------------------------------
    // Level bar
    //------------------------------------------------------------

    always_comb
    begin
        if (!next_sound[sound_w - 1])
            magnitude = next_sound;
        else if (next_sound == sound_min)
            magnitude = sound_max;                      // No positive twin
        else
            magnitude = -next_sound;
    end

    // LED k lit from 2**(k + level_base) up
    always_comb
    begin
        for (int k = 0; k < led_w; k++)
            next_level[k] = (int'(magnitude) >= (1 << (k + level_base)));
    end

    //------------------------------------------------------------
    // Handshake and output registers
    //------------------------------------------------------------

    assign accept = sample_req & ~sample_ack;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample_ack <= 1'b0;
            sound      <= '0;
            level      <= '0;
        end
        else
        begin
            if (accept)
            begin
                sample_ack <= 1'b1;
                sound      <= next_sound;               // Same edge as ack
                level      <= next_level;
            end
            else if (!sample_req)
                sample_ack <= 1'b0;                     // Closes the cycle
        end
    end

    // Ack only answers a live request
    assert property (@(posedge clk) disable iff (rst)
        !sample_req && !sample_ack |=> !sample_ack);

endmodule

/* design/i2s_audio_out.sv */
`timescale 1ns/1ps

`include "board_settings.svh"

module i2s_audio_out
#(
    parameter int clk_mhz = `BOARD_CLK_MHZ
)
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::sound_t data_in,
    output logic              mclk,
    output logic              bclk,
    output logic              lrclk,
    output logic              sdata
);

    import board_pkg::*;

    localparam int div_w    = $clog2(`AUD_BCLK_DIV + 1);
    localparam int cnt_w    = $clog2(2 * `I2S_SLOT_BITS);
    localparam int lrclk_hz = clk_mhz * 1_000_000 / (4 * `AUD_BCLK_DIV * `I2S_SLOT_BITS);

    logic [div_w - 1:0] div_cnt;
    logic               div_end;
    logic               bclk_fall;
    logic [cnt_w - 1:0] bit_cnt;
    logic [cnt_w - 1:0] next_cnt;
    logic               slot_start;     // lrclk edge on this bclk fall
    sound_t             word;           // Left word, replayed on the right
    sound_t             shift_reg;

    if (lrclk_hz < 8_000)
    begin : g_rate_check
        $error("DAC frame rate below supported range");
    end

    //------------------------------------------------------------
    // Clocks
    //------------------------------------------------------------

    assign div_end   = (div_cnt == div_w'(`AUD_BCLK_DIV - 1));
    assign bclk_fall = div_end & bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            mclk    <= ~mclk;                           // clk / 2
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;
            if (div_end)
                bclk <= ~bclk;
            if (bclk_fall)
                bit_cnt <= next_cnt;
        end
    end

    assign next_cnt   = bit_cnt + 1'b1;
    assign slot_start = (next_cnt[cnt_w - 2:0] == '0);
    assign lrclk      = bit_cnt[cnt_w - 1];             // Low for left slot

    //------------------------------------------------------------
    // Serializer
    //------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word      <= '0;
            shift_reg <= '0;
            sdata     <= 1'b0;
        end
        else if (bclk_fall)
        begin
            if (slot_start)
            begin
                sdata <= 1'b0;                          // One bclk delay slot
                if (!next_cnt[cnt_w - 1])
                begin
                    word      <= data_in;               // Sample at left start
                    shift_reg <= data_in;
                end
                else
                    shift_reg <= word;
            end
            else
            begin
                sdata     <= shift_reg[$bits(sound_t) - 1];
                shift_reg <= shift_reg << 1;            // Zeros pad the slot
            end
        end
    end

    // DAC expects word select to move on the falling bit clock
    assert property (@(posedge clk) disable iff (rst)
        $changed(lrclk) |-> $fell(bclk));

endmodule

/* design/board_specific_top.sv */
`timescale 1ns/1ps

`include "board_settings.svh"

module board_specific_top
#(
    parameter int clk_mhz = `BOARD_CLK_MHZ
)
(
    input  logic                      clk,

    input  logic [`BOARD_W_KEY - 1:0] key,      // Active low buttons
    input  logic [`BOARD_W_SW  - 1:0] sw,
    output logic [`BOARD_W_LED - 1:0] led,

    output logic                      mic_sck,
    output logic                      mic_ws,
    output logic                      mic_lr,
    output logic                      mic_gnd,
    output logic                      mic_vcc,
    input  logic                      mic_sd,

    output logic                      aud_mclk,
    output logic                      aud_bclk,
    output logic                      aud_lrclk,
    output logic                      aud_sdata
);

    import board_pkg::*;

    localparam int w_lab_sw = `BOARD_W_SW - 1;      // Top switch taken for reset

    logic                      rst;
    logic [`BOARD_W_KEY - 1:0] lab_key;
    atten_t                    lab_sw;

    mic_sample_t               sample;
    logic                      sample_req;
    logic                      sample_ack;
    sound_t                    sound;
    led_bar_t                  level;

    //------------------------------------------------------------
    // Board controls
    //------------------------------------------------------------

    assign rst     = sw[w_lab_sw];
    assign lab_sw  = sw[w_lab_sw - 1:0];
    assign lab_key = ~key;                          // Pressed reads as 1

    // Registered so the LEDs see no decode glitches
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else
            led <= level;
    end

    //------------------------------------------------------------
    // Microphone, powered from header pins
    //------------------------------------------------------------

    assign mic_gnd = 1'b0;
    assign mic_vcc = 1'b1;

    inmp441_mic_i2s_receiver #(.clk_mhz (clk_mhz)) i_microphone
    (
        .clk        (clk),
        .rst        (rst),
        .sck        (mic_sck),
        .ws         (mic_ws),
        .lr         (mic_lr),
        .sd         (mic_sd),
        .sample     (sample),
        .sample_req (sample_req),
        .sample_ack (sample_ack)
    );

    //------------------------------------------------------------
    // Lab core and DAC
    //------------------------------------------------------------

    sound_level_lab i_lab
    (
        .clk        (clk),
        .rst        (rst),
        .key        (lab_key),
        .sw         (lab_sw),
        .sample     (sample),
        .sample_req (sample_req),
        .sample_ack (sample_ack),
        .sound      (sound),
        .level      (level)
    );

    i2s_audio_out #(.clk_mhz (clk_mhz)) o_audio
    (
        .clk     (clk),
        .rst     (rst),
        .data_in (sound),
        .mclk    (aud_mclk),
        .bclk    (aud_bclk),
        .lrclk   (aud_lrclk),
        .sdata   (aud_sdata)
    );

endmodule

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    //------------------------------------------------------------
    // Failure exit
    //------------------------------------------------------------

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Testbench stopped");
    endtask

    //------------------------------------------------------------
    // Compares, one per result kind
    //------------------------------------------------------------

    task automatic check_sound(input sound_t got, input sound_t exp, input string name);
        if (got !== exp)
        begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input led_bar_t got, input led_bar_t exp, input string name);
        if (got !== exp)
        begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // Right slot repeats the left word
    task automatic check_right(input sound_t right, input sound_t left);
        if (right !== left)
        begin
            $display("Error at %0t: aud_sdata right word is %h, expected %h",
                     $time, right, left);
            stop_with_failure();
        end
    endtask

    // Single board pin
    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    //------------------------------------------------------------
    // Noise source and output capture
    //------------------------------------------------------------

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ 16'hB400;           // Feedback taps
        return shifted;
    endfunction

    // One full DAC frame, bit 0 of each slot is the delay bit
    task automatic capture_frame(input logic align, output sound_t left, output sound_t right);
        logic [frame_bits - 1:0] frame;
        frame = '0;
        if (align)
            @(negedge aud_lrclk);                   // Start of left slot
        for (int i = 0; i < frame_bits; i++)
        begin
            @(posedge aud_bclk);                    // Data settled since falling bclk
            frame = {frame[frame_bits - 2:0], aud_sdata};
        end
        left  = frame[frame_bits - 2 -: `SOUND_W];
        right = frame[`I2S_SLOT_BITS - 2 -: `SOUND_W];
    endtask

`endif

/* tests/tb_board_top.sv */
`timescale 1ns/1ps

`include "board_settings.svh"

module tb_board_top;

    import board_pkg::*;

    localparam int    clk_half_ns  = 4;
    localparam int    reset_cycles = 16;
    localparam int    frame_bits   = 2 * `I2S_SLOT_BITS;   // Bit clocks per frame
    localparam int    mic_w        = `MIC_SAMPLE_W;
    localparam int    rst_bit      = `BOARD_W_SW - 1;      // Top switch is reset
    localparam string data_path    = "tests/audio_testdata.txt";

    logic                      clk;
    logic [`BOARD_W_KEY - 1:0] key;
    logic [`BOARD_W_SW  - 1:0] sw;
    logic [`BOARD_W_LED - 1:0] led;
    logic                      mic_sck;
    logic                      mic_ws;
    logic                      mic_lr;
    logic                      mic_gnd;
    logic                      mic_vcc;
    logic                      mic_sd     = 1'b0;
    logic                      aud_mclk;
    logic                      aud_bclk;
    logic                      aud_lrclk;
    logic                      aud_sdata;

    // Vectors from the data file
    mic_sample_t               vec_mic[$];
    atten_t                    vec_sw[$];
    logic [`BOARD_W_KEY - 1:0] vec_key[$];
    sound_t                    vec_sound[$];
    led_bar_t                  vec_led[$];
    int                        n_vec;
    bit                        vectors_ready;

    // Microphone model state
    mic_sample_t               mic_word;                   // Word for the next left slot
    mic_sample_t               frame_word = '0;
    int                        slot_pos   = 0;
    logic                      prev_sck   = 1'b0;
    logic                      prev_ws    = 1'b1;
    logic [15:0]               lfsr_state = 16'd56;

    `include "tb_checks.svh"

    board_specific_top dut
    (
        .clk       (clk),
        .key       (key),
        .sw        (sw),
        .led       (led),
        .mic_sck   (mic_sck),
        .mic_ws    (mic_ws),
        .mic_lr    (mic_lr),
        .mic_gnd   (mic_gnd),
        .mic_vcc   (mic_vcc),
        .mic_sd    (mic_sd),
        .aud_mclk  (aud_mclk),
        .aud_bclk  (aud_bclk),
        .aud_lrclk (aud_lrclk),
        .aud_sdata (aud_sdata)
    );

    always #(clk_half_ns) clk = ~clk;                     // 8 ns period

    //------------------------------------------------------------
    // INMP441 model, follows the DUT's sck and ws
    //------------------------------------------------------------

    always @(negedge clk)
    begin
        if (prev_sck && !mic_sck)
        begin
            if (prev_ws && !mic_ws)
            begin
                slot_pos   = 0;                            // Left slot begins
                frame_word = mic_word;
            end
            else
                slot_pos = slot_pos + 1;
            if (!mic_ws && slot_pos >= 1 && slot_pos <= mic_w)
                mic_sd = frame_word[mic_w - slot_pos];     // MSB first, one bit late
            else
            begin
                mic_sd     = lfsr_state[0];                // Padding and right slot noise
                lfsr_state = lfsr_next(lfsr_state);
            end
        end
        prev_sck = mic_sck;
        prev_ws  = mic_ws;
    end

    //------------------------------------------------------------
    // Vector file and reset
    //------------------------------------------------------------

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_mic;
        logic [31:0] f_sw;
        logic [31:0] f_key;
        logic [31:0] f_snd;
        logic [31:0] f_led;
        fd = $fopen(data_path, "r");
        if (fd == 0)
        begin
            $display("Could not open the test data file %s", data_path);
            stop_with_failure();
        end
        else
        begin
            while (!$feof(fd))
            begin
                line  = "";
                count = $fgets(line, fd);
                if (line.len() > 0 && line.getc(0) != "#")
                begin
                    count = $sscanf(line, "%h %h %h %h %h", f_mic, f_sw, f_key, f_snd, f_led);
                    if (count == 5)
                    begin
                        vec_mic.push_back(f_mic[mic_w - 1:0]);
                        vec_sw.push_back(f_sw[`BOARD_W_SW - 2:0]);
                        vec_key.push_back(f_key[`BOARD_W_KEY - 1:0]);
                        vec_sound.push_back(f_snd[`SOUND_W - 1:0]);
                        vec_led.push_back(f_led[`BOARD_W_LED - 1:0]);
                    end
                end
            end
            $fclose(fd);
            n_vec = vec_mic.size();
            if (n_vec == 0)
            begin
                $display("The test data file holds no vectors");
                stop_with_failure();
            end
            else
                vectors_ready = 1'b1;
        end
    endtask

    // Reset already high, hold it, release and grab the first frame
    task automatic hold_reset();
        sound_t left;
        sound_t right;
        repeat (reset_cycles) @(negedge clk);
        check_level(led, '0, "led");
        check_bit(aud_sdata, 1'b0, "aud_sdata");           // Idle I2S lines
        check_bit(aud_lrclk, 1'b0, "aud_lrclk");
        check_bit(aud_bclk, 1'b0, "aud_bclk");
        check_bit(mic_sck, 1'b0, "mic_sck");
        check_bit(mic_ws, 1'b1, "mic_ws");
        sw[rst_bit] = 1'b0;
        capture_frame(1'b0, left, right);                  // Still the cleared serializer
        check_sound(left, '0, "aud_sdata left word");
        check_sound(right, '0, "aud_sdata right word");
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        sw[rst_bit] = 1'b1;
        hold_reset();
    endtask

    // Tied mic pins and the DAC master clock
    task automatic check_pins();
        logic mclk_before;
        @(negedge clk);
        check_bit(mic_lr, 1'b0, "mic_lr");
        check_bit(mic_gnd, 1'b0, "mic_gnd");
        check_bit(mic_vcc, 1'b1, "mic_vcc");
        mclk_before = aud_mclk;
        @(negedge clk);
        check_bit(aud_mclk, ~mclk_before, "aud_mclk");     // Half the system clock
    endtask

    //------------------------------------------------------------
    // One vector, mic frame in, DAC frame out
    //------------------------------------------------------------

    task automatic run_vector(input int i);
        sound_t left;
        sound_t right;
        @(negedge clk);
        while (!mic_ws)
            @(negedge clk);                                // Change only outside left slot
        sw[`BOARD_W_SW - 2:0] = vec_sw[i];
        key                   = vec_key[i];
        mic_word              = vec_mic[i];
        @(negedge mic_ws);                                 // Model takes the new word
        @(posedge mic_ws);                                 // Lab has the sample by now
        @(negedge aud_lrclk);                              // DAC latches the new sound
        capture_frame(1'b1, left, right);
        check_sound(left, vec_sound[i], "aud_sdata left word");
        check_right(right, left);
        check_level(led, vec_led[i], "led");
        check_pins();
    endtask

    initial
    begin
        clk          = 1'b0;
        sw           = '0;
        sw[rst_bit]  = 1'b1;
        key          = '1;                                 // No button pressed
        mic_word     = '0;
        load_vectors();
        hold_reset();
        check_level(led, '0, "led");
        for (int i = 0; i < n_vec; i++)
        begin
            if (i == n_vec / 2)
                pulse_reset();                             // Reset in the middle of the run
            run_vector(i);
        end
        $display("Finished with no errors");
        $finish;
    end

    // Four mic frames per vector plus both resets
    initial
    begin : watchdog
        longint limit_ns;
        wait (vectors_ready);
        limit_ns = longint'(n_vec) * 4 * frame_bits * 2 * `MIC_SCK_DIV * 2 * clk_half_ns
                 + 2 * reset_cycles * 2 * clk_half_ns;
        #(limit_ns);
        $display("Simulation timed out before all vectors were checked");
        stop_with_failure();
    end

endmodule

/* tests/audio_testdata.txt */
# mic_word(hex) sw_code(0-7) key(board level, bit low = pressed) sound(hex) led(hex)
# key bit 0 pressed mutes, sound is mic[23:8] >>> sw_code
000000 0 3 0000 00
7FFFFF 0 3 7FFF 7F
7FFFFF 1 3 3FFF 3F
7FFFFF 2 3 1FFF 1F
7FFFFF 3 3 0FFF 0F
7FFFFF 4 3 07FF 07
7FFFFF 5 3 03FF 03
7FFFFF 6 3 01FF 01
7FFFFF 7 3 00FF 00
800000 0 3 8000 7F
800000 1 3 C000 7F
800000 2 3 E000 3F
800000 3 3 F000 1F
800000 4 3 F800 0F
800000 5 3 FC00 07
800000 6 3 FE00 03
800000 7 3 FF00 01
FFFFFF 0 3 FFFF 00
FFFFFF 7 3 FFFF 00
123456 0 3 1234 1F
123456 3 3 0246 03
7FFFFF 0 2 0000 00
800000 0 2 0000 00
123456 0 1 1234 1F
4000AB 0 3 4000 7F
3FFFFF 0 3 3FFF 3F
0100FF 0 3 0100 01
00FFFF 0 3 00FF 00
FF00FF 0 3 FF00 01
FF0100 0 3 FF01 00
A5A5A5 2 3 E969 1F
A5A5A5 2 0 0000 00
5A5A5A 1 3 2D2D 3F
C00000 0 3 C000 7F
C00001 5 3 FE00 03
0800FF 0 3 0800 0F
07FF00 0 3 07FF 07
F80000 0 3 F800 0F
F80100 0 3 F801 07
654321 4 3 0654 07
8000FF 0 1 8000 7F

/* tb.f */
+incdir+design
+incdir+tests
design/board_pkg.sv
design/inmp441_mic_i2s_receiver.sv
design/sound_level_lab.sv
design/i2s_audio_out.sv
design/board_specific_top.sv
tests/tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the audio slice testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_board_top -Mdir obj_dir \
    && ./obj_dir/Vtb_board_top > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Finished with no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
